//--- common/csam_pkg.sv
package csam_pkg;

   localparam int op_width = 16;   // operand bits
   localparam int prod_width = 32; // full product bits

   // first array row reduced by the second csa stage
   localparam int split_row = 8;

   typedef logic [op_width-1:0] word_t;
   typedef logic [prod_width-1:0] product_t;

   // row r = multiplicand anded with multiplier bit r
   typedef logic [op_width-1:0][op_width-1:0] pp_array_t;

   // pp_gen output register
   typedef struct packed {
      logic valid;
      pp_array_t pp;
   } pp_stage_t;

   // running carry-save state between array stages
   typedef struct packed {
      logic valid;
      pp_array_t pp;                // rows still to be reduced
      logic [op_width-1:0] sum;     // msb is next row's leading term
      logic [op_width-2:0] carry;   // one carry per full adder column
      logic [op_width-1:0] low;     // retired product bits
   } csa_state_t;

endpackage

//--- rtl/pp_gen.sv
`timescale 1ns/1ps

module pp_gen (
   input  logic               clk,
   input  logic               reset,
   input  csam_pkg::word_t    x,
   input  csam_pkg::word_t    y,
   input  logic               in_valid,
   output csam_pkg::pp_stage_t out
);

   csam_pkg::pp_array_t terms;

   // one and term per multiplicand / multiplier bit pair
   always_comb begin
      for (int r = 0; r < csam_pkg::op_width; r++) begin
         for (int c = 0; c < csam_pkg::op_width; c++) begin
            terms[r][c] = x[c] & y[r]; // row r, column c
         end
      end
   end

   always_ff @(posedge clk) begin
      out.pp <= terms;
      if (reset) begin
         out.valid <= 1'b0;
      end else begin
         out.valid <= in_valid;
      end
   end

   // a valid pair must be fully defined
   a_operands_known: assert property (
      @(posedge clk) disable iff (reset)
      in_valid |-> !$isunknown({x, y})
   );

endmodule

//--- csa_array/csa_row_stage.sv
`timescale 1ns/1ps

module csa_row_stage #(
   parameter int first_row = 1,
   parameter int last_row = csam_pkg::split_row - 1
) (
   input  logic                 clk,
   input  logic                 reset,
   input  csam_pkg::pp_stage_t  pp_in,
   input  csam_pkg::csa_state_t state_in,
   output csam_pkg::csa_state_t state_out
);

   csam_pkg::csa_state_t start_s;
   csam_pkg::csa_state_t nxt_s;

   // head of the array seeds the state from row 0
   always_comb begin
      if (first_row == 1) begin
         start_s.valid = pp_in.valid;
         start_s.pp = pp_in.pp;
         start_s.sum = pp_in.pp[0];     // row 0 enters as the first sum
         start_s.carry = '0;
         start_s.low = '0;
         start_s.low[0] = pp_in.pp[0][0]; // product bit 0 needs no adder
      end else begin
         start_s = state_in;
      end
   end

   // one array row per iteration with its lsb retired
   always_comb begin
      logic [csam_pkg::op_width-1:0] s;
      logic [csam_pkg::op_width-2:0] cy;
      logic [csam_pkg::op_width-1:0] lo;
      logic [csam_pkg::op_width-1:0] row;
      logic [csam_pkg::op_width-1:0] s_new;
      logic [csam_pkg::op_width-2:0] cy_new;
      logic a;
      logic b;
      logic c;

      s = start_s.sum;
      cy = start_s.carry;
      lo = start_s.low;
      for (int r = first_row; r <= last_row; r++) begin
         row = start_s.pp[r];
         for (int i = 0; i < csam_pkg::op_width - 1; i++) begin
            a = row[i];
            b = s[i+1];  // previous sum shifted down one column
            c = cy[i];
            if (r == 1) begin
               s_new[i] = a ^ b;    // half adder as no carries exist yet
               cy_new[i] = a & b;
            end else begin
               s_new[i] = a ^ b ^ c;
               cy_new[i] = (a & b) | (a & c) | (b & c);
            end
         end
         s_new[csam_pkg::op_width-1] = row[csam_pkg::op_width-1]; // leading term
         s = s_new;
         cy = cy_new;
         lo[r] = s[0]; // retire bit r
      end

      nxt_s.valid = start_s.valid;
      nxt_s.pp = start_s.pp;
      nxt_s.sum = s;
      nxt_s.carry = cy;
      nxt_s.low = lo;
   end

   always_ff @(posedge clk) begin
      state_out.pp <= nxt_s.pp;
      state_out.sum <= nxt_s.sum;
      state_out.carry <= nxt_s.carry;
      state_out.low <= nxt_s.low;
      if (reset) begin
         state_out.valid <= 1'b0;
      end else begin
         state_out.valid <= nxt_s.valid;
      end
   end

   // strobe tracks whichever input this stage is built to take
   a_valid_follows: assert property (
      @(posedge clk) disable iff (reset)
      1'b1 |=> state_out.valid == $past(first_row == 1 ? pp_in.valid : state_in.valid)
   );

endmodule

//--- rtl/final_cpa.sv
`timescale 1ns/1ps

module final_cpa (
   input  logic                 clk,
   input  logic                 reset,
   input  csam_pkg::csa_state_t state_in,
   output csam_pkg::product_t   product,
   output logic                 out_valid
);

   logic [csam_pkg::op_width-1:0] upper;

   // ripple add of carry vector onto sum bits 15..1
   always_comb begin
      logic a;
      logic b;
      logic c;
      logic c_next;

      c = 1'b0;
      for (int i = 0; i < csam_pkg::op_width - 1; i++) begin
         a = state_in.carry[i];
         b = state_in.sum[i+1];
         c_next = (a & b) | (a & c) | (b & c);
         upper[i] = a ^ b ^ c;
         c = c_next;
      end
      upper[csam_pkg::op_width-1] = c; // carry out is product msb
   end

   always_ff @(posedge clk) begin
      product <= {upper, state_in.low};
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= state_in.valid;
      end
   end

   // in-flight pairs are dropped by reset
   a_reset_clears: assert property (
      @(posedge clk) reset |=> !out_valid
   );

endmodule

//--- rtl/csam_mul_top.sv
`timescale 1ns/1ps

module csam_mul_top (
   input  logic               clk,
   input  logic               reset,
   input  csam_pkg::word_t    x,
   input  csam_pkg::word_t    y,
   input  logic               in_valid,
   output csam_pkg::product_t product,
   output logic               out_valid
);

   csam_pkg::pp_stage_t  pp_s;   // partial products
   csam_pkg::csa_state_t mid_s;  // after upper half of array
   csam_pkg::csa_state_t last_s; // after all rows

   pp_gen u_pp_gen (
      .clk      (clk),
      .reset    (reset),
      .x        (x),
      .y        (y),
      .in_valid (in_valid),
      .out      (pp_s)
   );

   // rows 1 .. split_row-1, seeded from pp_gen
   csa_row_stage #(
      .first_row (1),
      .last_row  (csam_pkg::split_row - 1)
   ) u_csa_hi (
      .clk       (clk),
      .reset     (reset),
      .pp_in     (pp_s),
      .state_in  ('0),
      .state_out (mid_s)
   );

   // rows split_row .. 15
   csa_row_stage #(
      .first_row (csam_pkg::split_row),
      .last_row  (csam_pkg::op_width - 1)
   ) u_csa_lo (
      .clk       (clk),
      .reset     (reset),
      .pp_in     ('0),
      .state_in  (mid_s),
      .state_out (last_s)
   );

   final_cpa u_final_cpa (
      .clk       (clk),
      .reset     (reset),
      .state_in  (last_s),
      .product   (product),
      .out_valid (out_valid)
   );

endmodule

//--- verif/csam_clk_gen.sv
`timescale 1ns/1ps

module csam_clk_gen (
   input  logic reset_req,
   output logic clk,
   output logic reset
);

   logic por;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   initial begin
      por = 1'b1;
      repeat (16) @(posedge clk);
      #1;
      por = 1'b0;
   end

   assign reset = por | reset_req; // power-on or requested by the bench

endmodule

//--- verif/csam_mul_tb.sv
`timescale 1ns/1ps

module csam_mul_tb;

   localparam int latency = 4;
   localparam int table_size = 400;
   localparam int drain_timeout = 20;
   localparam int reset_timeout = 40;
   localparam logic [31:0] seed = 32'h57a09d14;

   typedef struct packed {
      csam_pkg::word_t x;
      csam_pkg::word_t y;
      logic valid;
   } stim_t;

   logic clk;
   logic reset;
   logic reset_req;
   csam_pkg::word_t x;
   csam_pkg::word_t y;
   logic in_valid;
   csam_pkg::product_t product;
   logic out_valid;

   stim_t stim_table [table_size];
   int table_fill = 0;
   logic [31:0] lfsr_state = seed;
   csam_pkg::product_t exp_q [$];
   logic [latency-1:0] pipe_valid = '0; // model of the stage valid registers
   int mismatch_errors = 0;
   int other_errors = 0;
   int checked = 0;

   csam_clk_gen u_clk_gen (
      .reset_req (reset_req),
      .clk       (clk),
      .reset     (reset)
   );

   csam_mul_top uut (
      .clk       (clk),
      .reset     (reset),
      .x         (x),
      .y         (y),
      .in_valid  (in_valid),
      .product   (product),
      .out_valid (out_valid)
   );

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic csam_pkg::word_t take_bits(input int n);
      csam_pkg::word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic add_entry(input csam_pkg::word_t a, input csam_pkg::word_t b,
                            input logic v);
      if (table_fill < table_size) begin
         stim_table[table_fill] = '{x: a, y: b, valid: v};
         table_fill++;
      end else begin
         $display("ERROR: stimulus table is full");
         other_errors++;
      end
   endtask

   task automatic check_product(input csam_pkg::product_t got,
                                input csam_pkg::product_t exp);
      if (got !== exp) begin
         $display("MISMATCH product got %h expected %h", got, exp);
         mismatch_errors++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH out_valid got %h expected %h", got, exp);
         mismatch_errors++;
      end
   endtask

   task automatic apply_range(input int first, input int last);
      for (int i = first; i < last; i++) begin
         @(posedge clk);
         #1;
         x = stim_table[i].x;
         y = stim_table[i].y;
         in_valid = stim_table[i].valid;
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain(input string phase);
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 && cycles < drain_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         $display("ERROR: %s timed out with %0d products still missing", phase, exp_q.size());
         other_errors++;
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (reset !== 1'b0 && cycles < reset_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (reset !== 1'b0) begin
         $display("ERROR: reset never went low");
         other_errors++;
      end
   endtask

   // outputs and driven inputs are settled at mid-cycle
   initial begin
      @(posedge clk); // skip the x to 0 step of clk at time 0
      forever begin
         @(negedge clk);
         check_valid(out_valid, pipe_valid[latency-1]);
         if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               $display("ERROR: out_valid was high with no product expected");
               other_errors++;
            end else begin
               check_product(product, exp_q.pop_front());
               checked++;
            end
         end
         if (reset === 1'b1) begin
            pipe_valid = '0; // everything in flight is dropped
            exp_q.delete();
         end else begin
            pipe_valid = {pipe_valid[latency-2:0], in_valid};
            if (in_valid === 1'b1) begin
               exp_q.push_back(csam_pkg::product_t'(x) * csam_pkg::product_t'(y));
            end
         end
      end
   end

   initial begin
      int dir_end;
      int stream_end;
      int gap_end;
      int pre_end;

      reset_req = 1'b0;
      x = '0;
      y = '0;
      in_valid = 1'b0;

      add_entry(16'h0000, 16'h1234, 1'b1);
      add_entry(16'hffff, 16'h0000, 1'b1);
      add_entry(16'h0001, 16'hbeef, 1'b1);
      add_entry(16'h7f3a, 16'h0001, 1'b1);
      add_entry(16'hffff, 16'hffff, 1'b1);
      add_entry(16'hffff, 16'h0001, 1'b1);
      add_entry(16'h0001, 16'hffff, 1'b1);
      for (int i = 0; i < 16; i++) begin
         add_entry(16'h0001 << i, 16'h9e37, 1'b1); // powers of two
         add_entry(16'h0001 << i, 16'h8000 >> i, 1'b1);
      end
      add_entry(16'haaaa, 16'h5555, 1'b1); // long carry chains
      add_entry(16'h5555, 16'haaaa, 1'b1);
      add_entry(16'h8000, 16'h8000, 1'b1);
      add_entry(16'hffff, 16'h8001, 1'b1);
      dir_end = table_fill;
      for (int i = 0; i < 200; i++) begin
         add_entry(take_bits(16), take_bits(16), 1'b1);
      end
      stream_end = table_fill;
      for (int i = 0; i < 120; i++) begin
         add_entry(take_bits(16), take_bits(16), take_bits(2) != 0);
      end
      gap_end = table_fill;
      for (int i = 0; i < 12; i++) begin
         add_entry(take_bits(16), take_bits(16), 1'b1);
      end
      pre_end = table_fill;
      for (int i = 0; i < 24; i++) begin
         add_entry(take_bits(16), take_bits(16), 1'b1);
      end

      wait_reset_release();
      apply_range(0, dir_end);
      wait_drain("directed operands");
      apply_range(dir_end, stream_end);
      wait_drain("full-rate stream");
      apply_range(stream_end, gap_end);
      wait_drain("stream with gaps");

      apply_range(gap_end, pre_end);
      reset_req = 1'b1; // pairs from the last burst are still in flight
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
      end
      #1;
      reset_req = 1'b0;
      wait_reset_release();
      for (int i = 0; i < 6; i++) begin
         @(posedge clk); // out_valid must stay low while idle
      end
      apply_range(pre_end, table_fill);
      wait_drain("after reset");

      if (checked == 0) begin
         $display("ERROR: no products were checked");
         other_errors++;
      end
      $display("errors: %0d mismatches, %0d other, %0d products checked",
               mismatch_errors, other_errors, checked);
      if (mismatch_errors == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- csam_mul.f
common/csam_pkg.sv
rtl/pp_gen.sv
csa_array/csa_row_stage.sv
rtl/final_cpa.sv
rtl/csam_mul_top.sv
verif/csam_clk_gen.sv
verif/csam_mul_tb.sv

//--- Bender.yml
package:
  name: csam_mul

sources:
  - common/csam_pkg.sv
  - rtl/pp_gen.sv
  - csa_array/csa_row_stage.sv
  - rtl/final_cpa.sv
  - rtl/csam_mul_top.sv
  - target: test
    files:
      - verif/csam_clk_gen.sv
      - verif/csam_mul_tb.sv
